// File: ia_subsys_top.f
+incdir+rtl
rtl/ia_pkg.sv
rtl/ia_cmd_decode.sv
rtl/ia_grant_timer.sv
rtl/ia_ctrl_fsm.sv
rtl/ia_data_path.sv
rtl/ia_table_mem.sv
rtl/ia_subsys_top.sv
sim/ia_subsys_tb.sv

// File: rtl/ia_cmd_decode.sv
// Purely combinational decode, so strobes are valid only in the wr_stb cycle
`timescale 1ns/10ps
`include "ia_params.svh"

module ia_cmd_decode (
  input  logic                      wr_stb,
  input  logic [`IA_REG_ADDR_W-1:0] reg_addr,
  input  ia_pkg::ia_op_e            cmnd_op,
  output logic                      rd_stb,
  output logic                      wr_op_stb,
  output logic                      ena_stb,
  output logic                      dis_stb,
  output logic                      rst_stb,
  output logic                      ini_stb,
  output logic                      inc_stb,
  output logic                      sis_stb,
  output logic                      cmp_stb,
  output logic                      ack_stb,
  output logic                      cmnd_issued,
  output logic                      unsupported_op
);

  always_comb begin
    rd_stb         = 1'b0;
    wr_op_stb      = 1'b0;
    ena_stb        = 1'b0;
    dis_stb        = 1'b0;
    rst_stb        = 1'b0;
    ini_stb        = 1'b0;
    inc_stb        = 1'b0;
    sis_stb        = 1'b0;
    cmp_stb        = 1'b0;
    ack_stb        = 1'b0;
    cmnd_issued    = 1'b0;
    unsupported_op = 1'b0;
    if (wr_stb && (reg_addr == `IA_CMND_ADDR)) begin
      cmnd_issued = 1'b1;
      case (cmnd_op)
        ia_pkg::NOP            : cmnd_issued = 1'b0; // Not a command
        ia_pkg::READ           : rd_stb = 1'b1;
        ia_pkg::WRITE          : wr_op_stb = 1'b1;
        ia_pkg::ENABLE         : ena_stb = 1'b1;
        ia_pkg::DISABLE        : dis_stb = 1'b1;
        ia_pkg::RESET          : rst_stb = 1'b1;
        ia_pkg::INIT           : ini_stb = 1'b1;
        ia_pkg::INIT_INC       : inc_stb = 1'b1;
        ia_pkg::SET_INIT_START : sis_stb = 1'b1;
        ia_pkg::COMPARE        : cmp_stb = 1'b1;
        ia_pkg::ACK_ERROR      : ack_stb = 1'b1;
        default                : unsupported_op = 1'b1;
      endcase
    end
  end

endmodule

// File: rtl/ia_ctrl_fsm.sv
// One command at a time; a second command while busy is OVR and the table powers up disabled
`timescale 1ns/10ps

module ia_ctrl_fsm (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             rd_stb,
  input  logic             wr_op_stb,
  input  logic             ena_stb,
  input  logic             dis_stb,
  input  logic             rst_stb,
  input  logic             ini_stb,
  input  logic             inc_stb,
  input  logic             sis_stb,
  input  logic             cmp_stb,
  input  logic             ack_stb,
  input  logic             cmnd_issued,
  input  logic             unsupported_op,
  input  ia_pkg::ia_addr_t cmnd_addr,
  input  ia_pkg::ia_addr_t addr_limit,
  input  logic             grant,
  input  logic             timeout,
  output logic             busy,
  output logic             sw_cs,
  output logic             sw_we,
  output logic             sw_ce,
  output logic             fill_sel,
  output ia_pkg::ia_addr_t fill_addr,
  output logic             ld_inc,
  output logic             step_inc,
  output logic             wdat_sel_reset,
  output logic             cap_rd,
  output logic             cap_cmp,
  output ia_pkg::ia_stat_e stat_code,
  output logic             enable
);

  ia_pkg::ia_state_e state_r;
  ia_pkg::ia_state_e state_nxt;
  ia_pkg::ia_addr_t  max_addr;
  logic              bad_addr;
  logic              init_inc_r;

  assign max_addr = enable ? addr_limit : '0; // Nothing but entry 0 while disabled
  assign bad_addr = cmnd_issued && (cmnd_addr > max_addr);
  assign busy     = (state_r != ia_pkg::POWERDOWN) && (state_r != ia_pkg::READY) &&
                    (state_r != ia_pkg::ERROR);

  assign ld_inc   = (state_r == ia_pkg::READY);
  assign step_inc = (state_r == ia_pkg::DO_INIT) && init_inc_r && grant;
  assign cap_rd   = (state_r == ia_pkg::READ_DONE);
  assign cap_cmp  = (state_r == ia_pkg::COMPARE_DONE);

  always_comb begin
    state_nxt = state_r;
    if (bad_addr) begin
      state_nxt = ia_pkg::ERROR;
    end else begin
      case (state_r)
        ia_pkg::POWERDOWN    : if (ena_stb) state_nxt = ia_pkg::READY;
        ia_pkg::READY        : begin
          if (wr_op_stb)                state_nxt = ia_pkg::DO_WRITE;
          else if (rd_stb)              state_nxt = ia_pkg::DO_READ;
          else if (cmp_stb)             state_nxt = ia_pkg::DO_COMPARE;
          else if (rst_stb)             state_nxt = ia_pkg::DO_RESET;
          else if (ini_stb || inc_stb)  state_nxt = ia_pkg::DO_INIT;
          else if (dis_stb)             state_nxt = ia_pkg::POWERDOWN;
          else if (unsupported_op)      state_nxt = ia_pkg::ERROR;
        end
        ia_pkg::DO_WRITE     : if (grant) state_nxt = ia_pkg::READY;
        ia_pkg::DO_READ      : if (grant) state_nxt = ia_pkg::READ_DONE;
        ia_pkg::DO_COMPARE   : if (grant) state_nxt = ia_pkg::COMPARE_WAIT;
        ia_pkg::DO_RESET     : if (grant && fill_addr == max_addr) state_nxt = ia_pkg::READY;
        ia_pkg::DO_INIT      : if (grant && fill_addr == cmnd_addr) state_nxt = ia_pkg::READY;
        ia_pkg::COMPARE_WAIT : state_nxt = ia_pkg::COMPARE_DONE;
        ia_pkg::READ_DONE,
        ia_pkg::COMPARE_DONE : state_nxt = ia_pkg::READY;
        default              : if (ack_stb) state_nxt = enable ? ia_pkg::READY : ia_pkg::POWERDOWN;
      endcase
    end
    if ((timeout || cmnd_issued) && busy) begin
      state_nxt = ia_pkg::ERROR; // Stalled too long or overrun
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_r        <= ia_pkg::POWERDOWN;
      stat_code      <= ia_pkg::PDN;
      enable         <= 1'b0;
      sw_cs          <= 1'b0;
      sw_we          <= 1'b0;
      sw_ce          <= 1'b0;
      fill_sel       <= 1'b0;
      wdat_sel_reset <= 1'b0;
      fill_addr      <= '0;
      init_inc_r     <= 1'b0;
    end else begin
      state_r <= state_nxt;
      if (state_r == ia_pkg::POWERDOWN && state_nxt == ia_pkg::READY) begin
        enable <= 1'b1;
      end else if (state_nxt == ia_pkg::POWERDOWN) begin
        enable <= 1'b0;
      end
      if (state_r == ia_pkg::READY) begin
        init_inc_r <= inc_stb;
      end
      if (state_r == ia_pkg::READY && sis_stb && !bad_addr) begin
        fill_addr <= cmnd_addr;
      end else if (state_r == ia_pkg::READY && rst_stb) begin
        fill_addr <= '0; // RESET always starts at entry 0
      end else if (fill_sel && grant) begin
        fill_addr <= ia_pkg::ia_addr_t'(fill_addr + 1'b1);
      end
      sw_cs          <= state_nxt inside {ia_pkg::DO_WRITE, ia_pkg::DO_READ, ia_pkg::DO_COMPARE,
                                          ia_pkg::DO_RESET, ia_pkg::DO_INIT};
      sw_we          <= state_nxt inside {ia_pkg::DO_WRITE, ia_pkg::DO_RESET, ia_pkg::DO_INIT};
      sw_ce          <= (state_nxt == ia_pkg::DO_COMPARE);
      fill_sel       <= state_nxt inside {ia_pkg::DO_RESET, ia_pkg::DO_INIT};
      wdat_sel_reset <= (state_nxt == ia_pkg::DO_RESET);
      case (state_nxt)
        ia_pkg::POWERDOWN : stat_code <= ia_pkg::PDN;
        ia_pkg::READY     : stat_code <= ia_pkg::RDY;
        ia_pkg::ERROR     : begin
          if (state_r != ia_pkg::ERROR) begin // Code kept until ACK_ERROR
            if (unsupported_op)  stat_code <= ia_pkg::UOP;
            else if (bad_addr)   stat_code <= ia_pkg::NXM;
            else if (timeout)    stat_code <= ia_pkg::TMO;
            else                 stat_code <= ia_pkg::OVR;
          end
        end
        default           : stat_code <= ia_pkg::BSY;
      endcase
    end
  end

  a_stall_holds_cs : assert property (@(posedge clk) disable iff (!rst_n)
                                      sw_cs && !grant && !timeout && !cmnd_issued |=> sw_cs)
    else $error("ia_ctrl_fsm: stalled access dropped its request");

endmodule

// File: rtl/ia_data_path.sv
// Write data is the command data latched while READY, so wr_dat may change once a fill starts
`timescale 1ns/10ps
`include "ia_params.svh"

module ia_data_path (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ld_inc,
  input  logic             step_inc,
  input  logic             wdat_sel_reset,
  input  logic             cap_rd,
  input  logic             cap_cmp,
  input  ia_pkg::ia_data_t wr_dat,
  input  ia_pkg::ia_data_t sw_rdat,
  input  logic             match,
  input  ia_pkg::ia_addr_t match_idx,
  output ia_pkg::ia_data_t sw_wdat,
  output ia_pkg::ia_data_t rd_dat
);

  ia_pkg::ia_data_t inc_r;

  // Tracks wr_dat while idle, then steps once per granted INIT_INC entry
  always_ff @(posedge clk) begin
    if (ld_inc) begin
      inc_r <= wr_dat;
    end else if (step_inc) begin
      inc_r <= inc_r + 1'b1;
    end
  end

  assign sw_wdat = wdat_sel_reset ? ia_pkg::ia_data_t'(`IA_RESET_DATA) : inc_r;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_dat <= '0;
    end else if (cap_rd) begin
      rd_dat <= sw_rdat;
    end else if (cap_cmp) begin
      rd_dat <= ia_pkg::ia_data_t'({match, match_idx}); // Match flag above the index
    end
  end

endmodule

// File: rtl/ia_grant_timer.sv
// Saturates at all ones and clears on any grant or whenever count drops
`timescale 1ns/10ps
`include "ia_params.svh"

module ia_grant_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic count,
  input  logic grant,
  output logic yield,
  output logic timeout
);

  logic [`IA_TIMER_W-1:0] cnt_r;

  assign timeout = &cnt_r;
  assign yield   = cnt_r[`IA_TIMER_W-1]; // Halfway, ask hw side to back off

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_r <= '0;
    end else if (count && !grant) begin
      if (!timeout) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end else begin
      cnt_r <= '0;
    end
  end

endmodule

// File: rtl/ia_params.svh
// Build-time sizes and register map, with the table depth set by IA_ADDR_W (2**IA_ADDR_W entries)
`ifndef IA_PARAMS_SVH
`define IA_PARAMS_SVH

// Table geometry
`define IA_DATA_W 32
`define IA_ADDR_W 4

// Software register map
`define IA_REG_ADDR_W 8
`define IA_CMND_ADDR 8'h04

// Grant timer, MSB raises yield and all ones ends the operation
`define IA_TIMER_W 6

// Fill value written by the RESET opcode
`define IA_RESET_DATA 32'h0

`endif

// File: rtl/ia_pkg.sv
// Shared types of the table controller, with vector widths taken from the params header
`include "ia_params.svh"

package ia_pkg;

  typedef logic [`IA_DATA_W-1:0] ia_data_t;
  typedef logic [`IA_ADDR_W-1:0] ia_addr_t;

  typedef enum logic [3:0] {
    NOP            = 4'h0,
    READ           = 4'h1,
    WRITE          = 4'h2,
    ENABLE         = 4'h3,
    DISABLE        = 4'h4,
    RESET          = 4'h5,
    INIT           = 4'h6,
    INIT_INC       = 4'h7,
    SET_INIT_START = 4'h8,
    COMPARE        = 4'h9,
    ACK_ERROR      = 4'hf
  } ia_op_e;

  typedef enum logic [2:0] {
    RDY = 3'h0,
    BSY = 3'h1,
    TMO = 3'h2,
    OVR = 3'h3,
    NXM = 3'h4,
    UOP = 3'h5,
    PDN = 3'h7
  } ia_stat_e;

  typedef enum logic [3:0] {POWERDOWN, READY, ERROR, DO_RESET, DO_INIT, DO_WRITE,
                            DO_READ, READ_DONE, DO_COMPARE, COMPARE_WAIT,
                            COMPARE_DONE} ia_state_e;

endpackage

// File: rtl/ia_subsys_top.sv
// Software reaches the table only via the command register and must ACK_ERROR any error
`timescale 1ns/10ps
`include "ia_params.svh"

module ia_subsys_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wr_stb,
  input  logic [`IA_REG_ADDR_W-1:0] reg_addr,
  input  ia_pkg::ia_op_e            cmnd_op,
  input  ia_pkg::ia_addr_t          cmnd_addr,
  input  ia_pkg::ia_data_t          wr_dat,
  input  ia_pkg::ia_addr_t          addr_limit,
  input  logic                      hw_req,
  input  ia_pkg::ia_addr_t          hw_addr,
  output ia_pkg::ia_stat_e          stat_code,
  output ia_pkg::ia_data_t          rd_dat,
  output logic                      enable,
  output logic                      yield,
  output ia_pkg::ia_data_t          hw_rdat
);

  logic             rd_stb;
  logic             wr_op_stb;
  logic             ena_stb;
  logic             dis_stb;
  logic             rst_stb;
  logic             ini_stb;
  logic             inc_stb;
  logic             sis_stb;
  logic             cmp_stb;
  logic             ack_stb;
  logic             cmnd_issued;
  logic             unsupported_op;
  logic             busy;
  logic             sw_cs;
  logic             sw_we;
  logic             sw_ce;
  logic             fill_sel;
  ia_pkg::ia_addr_t fill_addr;
  logic             ld_inc;
  logic             step_inc;
  logic             wdat_sel_reset;
  logic             cap_rd;
  logic             cap_cmp;
  logic             grant;
  logic             timeout;
  ia_pkg::ia_data_t sw_wdat;
  ia_pkg::ia_data_t sw_rdat;
  logic             match;
  ia_pkg::ia_addr_t match_idx;

  ia_cmd_decode decode_i (
    .wr_stb         (wr_stb),
    .reg_addr       (reg_addr),
    .cmnd_op        (cmnd_op),
    .rd_stb         (rd_stb),
    .wr_op_stb      (wr_op_stb),
    .ena_stb        (ena_stb),
    .dis_stb        (dis_stb),
    .rst_stb        (rst_stb),
    .ini_stb        (ini_stb),
    .inc_stb        (inc_stb),
    .sis_stb        (sis_stb),
    .cmp_stb        (cmp_stb),
    .ack_stb        (ack_stb),
    .cmnd_issued    (cmnd_issued),
    .unsupported_op (unsupported_op)
  );

  ia_ctrl_fsm fsm_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_stb         (rd_stb),
    .wr_op_stb      (wr_op_stb),
    .ena_stb        (ena_stb),
    .dis_stb        (dis_stb),
    .rst_stb        (rst_stb),
    .ini_stb        (ini_stb),
    .inc_stb        (inc_stb),
    .sis_stb        (sis_stb),
    .cmp_stb        (cmp_stb),
    .ack_stb        (ack_stb),
    .cmnd_issued    (cmnd_issued),
    .unsupported_op (unsupported_op),
    .cmnd_addr      (cmnd_addr),
    .addr_limit     (addr_limit),
    .grant          (grant),
    .timeout        (timeout),
    .busy           (busy),
    .sw_cs          (sw_cs),
    .sw_we          (sw_we),
    .sw_ce          (sw_ce),
    .fill_sel       (fill_sel),
    .fill_addr      (fill_addr),
    .ld_inc         (ld_inc),
    .step_inc       (step_inc),
    .wdat_sel_reset (wdat_sel_reset),
    .cap_rd         (cap_rd),
    .cap_cmp        (cap_cmp),
    .stat_code      (stat_code),
    .enable         (enable)
  );

  ia_grant_timer timer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .count   (busy), // Only busy states can stall
    .grant   (grant),
    .yield   (yield),
    .timeout (timeout)
  );

  ia_data_path data_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ld_inc         (ld_inc),
    .step_inc       (step_inc),
    .wdat_sel_reset (wdat_sel_reset),
    .cap_rd         (cap_rd),
    .cap_cmp        (cap_cmp),
    .wr_dat         (wr_dat),
    .sw_rdat        (sw_rdat),
    .match          (match),
    .match_idx      (match_idx),
    .sw_wdat        (sw_wdat),
    .rd_dat         (rd_dat)
  );

  ia_table_mem table_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .sw_cs     (sw_cs),
    .sw_we     (sw_we),
    .sw_ce     (sw_ce),
    .fill_sel  (fill_sel),
    .fill_addr (fill_addr),
    .cmnd_addr (cmnd_addr),
    .sw_wdat   (sw_wdat),
    .wr_dat    (wr_dat),
    .hw_req    (hw_req),
    .hw_addr   (hw_addr),
    .grant     (grant),
    .sw_rdat   (sw_rdat),
    .match     (match),
    .match_idx (match_idx),
    .hw_rdat   (hw_rdat)
  );

endmodule

// File: rtl/ia_table_mem.sv
// Single-port table, hw lookups win only while enabled and compare scans all entries in one cycle
`timescale 1ns/10ps
`include "ia_params.svh"

module ia_table_mem (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable,
  input  logic             sw_cs,
  input  logic             sw_we,
  input  logic             sw_ce,
  input  logic             fill_sel,
  input  ia_pkg::ia_addr_t fill_addr,
  input  ia_pkg::ia_addr_t cmnd_addr,
  input  ia_pkg::ia_data_t sw_wdat,
  input  ia_pkg::ia_data_t wr_dat,
  input  logic             hw_req,
  input  ia_pkg::ia_addr_t hw_addr,
  output logic             grant,
  output ia_pkg::ia_data_t sw_rdat,
  output logic             match,
  output ia_pkg::ia_addr_t match_idx,
  output ia_pkg::ia_data_t hw_rdat
);

  localparam int unsigned N_ENTRIES = 2 ** `IA_ADDR_W;

  ia_pkg::ia_data_t mem [N_ENTRIES];
  ia_pkg::ia_addr_t sw_addr;
  logic             hit;
  ia_pkg::ia_addr_t hit_idx;

  assign sw_addr = fill_sel ? fill_addr : cmnd_addr;
  assign grant   = sw_cs && !(enable && hw_req); // hw port has priority

  // Scan from the top so the lowest matching index wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = N_ENTRIES - 1; i >= 0; i--) begin
      if (mem[i] == wr_dat) begin
        hit     = 1'b1;
        hit_idx = ia_pkg::ia_addr_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant && sw_we) begin
      mem[sw_addr] <= sw_wdat;
    end
    if (grant && !sw_we && !sw_ce) begin
      sw_rdat <= mem[sw_addr];
    end
    if (grant && sw_ce) begin
      match_idx <= hit_idx;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      match   <= 1'b0;
      hw_rdat <= '0;
    end else begin
      if (grant && sw_ce) begin
        match <= hit;
      end
      if (hw_req && enable) begin
        hw_rdat <= mem[hw_addr]; // Lookup data one cycle after request
      end
    end
  end

  a_well_formed_req : assert property (@(posedge clk) disable iff (!rst_n)
                                       (sw_we || sw_ce) |-> sw_cs && !(sw_we && sw_ce))
    else $error("ia_table_mem: write or compare without a single chip-select access");

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ia_subsys_tb -f ia_subsys_top.f -o ia_subsys_sim

./obj_dir/ia_subsys_sim | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: sim/ia_subsys_tb.sv
// Drives the command register only and expects a 16-entry table that powers up disabled
`timescale 1ns/10ps
`include "ia_params.svh"

module ia_subsys_tb;

  localparam int MAX_ROWS  = 64;
  localparam int N_ENTRIES = 2 ** `IA_ADDR_W;
  localparam int YIELD_AT  = 2 ** (`IA_TIMER_W - 1);
  localparam int STALL_MAX = 2 ** `IA_TIMER_W;

  logic                      clk;
  logic                      rst_n;
  logic                      wr_stb;
  logic [`IA_REG_ADDR_W-1:0] reg_addr;
  ia_pkg::ia_op_e            cmnd_op;
  ia_pkg::ia_addr_t          cmnd_addr;
  ia_pkg::ia_data_t          wr_dat;
  ia_pkg::ia_addr_t          addr_limit;
  logic                      hw_req;
  ia_pkg::ia_addr_t          hw_addr;
  ia_pkg::ia_stat_e          stat_code;
  ia_pkg::ia_data_t          rd_dat;
  logic                      enable;
  logic                      yield;
  ia_pkg::ia_data_t          hw_rdat;

  // One row per command or hw lookup
  logic [3:0]       row_op    [MAX_ROWS];
  ia_pkg::ia_addr_t row_addr  [MAX_ROWS];
  ia_pkg::ia_data_t row_data  [MAX_ROWS];
  ia_pkg::ia_addr_t row_limit [MAX_ROWS];
  int               row_hold  [MAX_ROWS]; // Cycles hw_req stays high
  logic             row_ovr   [MAX_ROWS]; // Second command inside the stall
  logic             row_hw    [MAX_ROWS];
  ia_pkg::ia_stat_e row_stat  [MAX_ROWS];
  ia_pkg::ia_data_t row_rd    [MAX_ROWS];
  logic             row_ena   [MAX_ROWS];
  int               n_rows;

  ia_pkg::ia_data_t model_mem [N_ENTRIES];
  ia_pkg::ia_addr_t model_fill;
  ia_pkg::ia_data_t model_rd;
  logic             model_ena;

  integer seed;
  int     n_errors;
  int     n_checks;
  int     cycle_cnt;
  int     cycle_limit;

  ia_subsys_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_stb     (wr_stb),
    .reg_addr   (reg_addr),
    .cmnd_op    (cmnd_op),
    .cmnd_addr  (cmnd_addr),
    .wr_dat     (wr_dat),
    .addr_limit (addr_limit),
    .hw_req     (hw_req),
    .hw_addr    (hw_addr),
    .stat_code  (stat_code),
    .rd_dat     (rd_dat),
    .enable     (enable),
    .yield      (yield),
    .hw_rdat    (hw_rdat)
  );

  always #20 clk = ~clk;

  task automatic check_val(input string what, input ia_pkg::ia_data_t got,
                           input ia_pkg::ia_data_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Table contents after a command that completed without error
  task automatic model_update(input logic [3:0] op, input ia_pkg::ia_addr_t addr,
                              input ia_pkg::ia_data_t data, input ia_pkg::ia_addr_t limit);
    ia_pkg::ia_addr_t a;
    ia_pkg::ia_data_t v;
    logic             done;
    case (op)
      ia_pkg::READ           : model_rd = model_mem[addr];
      ia_pkg::WRITE          : model_mem[addr] = data;
      ia_pkg::ENABLE         : model_ena = 1'b1;
      ia_pkg::DISABLE        : model_ena = 1'b0;
      ia_pkg::SET_INIT_START : model_fill = addr;
      ia_pkg::RESET          : begin
        for (int i = 0; i <= int'(limit); i++) begin
          model_mem[i] = `IA_RESET_DATA;
        end
        model_fill = ia_pkg::ia_addr_t'(limit + 1);
      end
      ia_pkg::INIT, ia_pkg::INIT_INC : begin
        a    = model_fill;
        v    = data;
        done = 1'b0;
        while (!done) begin
          model_mem[a] = v;
          if (op == ia_pkg::INIT_INC) v = v + 1;
          done = (a == addr);
          a    = ia_pkg::ia_addr_t'(a + 1);
        end
        model_fill = a;
      end
      ia_pkg::COMPARE        : begin
        done     = 1'b0;
        model_rd = '0;
        for (int i = 0; i < N_ENTRIES; i++) begin
          if (!done && model_mem[i] == data) begin
            model_rd = ia_pkg::ia_data_t'((1 << `IA_ADDR_W) | i); // Match flag over index
            done     = 1'b1;
          end
        end
      end
      default                : ;
    endcase
  endtask

  task automatic add_cmd(input logic [3:0] op, input int addr, input ia_pkg::ia_data_t data,
                         input int limit, input int hold, input logic ovr,
                         input ia_pkg::ia_stat_e stat);
    row_op[n_rows]    = op;
    row_addr[n_rows]  = ia_pkg::ia_addr_t'(addr);
    row_data[n_rows]  = data;
    row_limit[n_rows] = ia_pkg::ia_addr_t'(limit);
    row_hold[n_rows]  = hold;
    row_ovr[n_rows]   = ovr;
    row_hw[n_rows]    = 1'b0;
    row_stat[n_rows]  = stat;
    if (stat == ia_pkg::RDY || stat == ia_pkg::PDN) begin
      model_update(op, row_addr[n_rows], data, row_limit[n_rows]);
    end
    row_rd[n_rows]  = model_rd;
    row_ena[n_rows] = model_ena;
    n_rows++;
  endtask

  task automatic add_lookup(input int addr);
    row_op[n_rows]   = ia_pkg::NOP;
    row_addr[n_rows] = ia_pkg::ia_addr_t'(addr);
    row_hold[n_rows] = 0;
    row_ovr[n_rows]  = 1'b0;
    row_hw[n_rows]   = 1'b1;
    row_rd[n_rows]   = model_mem[addr];
    n_rows++;
  endtask

  task automatic build_table();
    int               waddr [6];
    ia_pkg::ia_data_t key;
    waddr = '{0, 3, 5, 9, 12, 15};
    add_cmd(ia_pkg::READ, 1, '0, 15, 0, 1'b0, ia_pkg::NXM); // Disabled, only entry 0 exists
    add_cmd(ia_pkg::ACK_ERROR, 0, '0, 15, 0, 1'b0, ia_pkg::PDN);
    add_cmd(ia_pkg::ENABLE, 0, '0, 15, 0, 1'b0, ia_pkg::RDY);
    for (int i = 0; i < 6; i++) begin
      add_cmd(ia_pkg::WRITE, waddr[i], $random(seed), 15, 0, 1'b0, ia_pkg::RDY);
    end
    for (int i = 0; i < 6; i++) begin
      add_cmd(ia_pkg::READ, waddr[i], '0, 15, 0, 1'b0, ia_pkg::RDY);
    end
    for (int i = 0; i < 6; i++) begin
      add_lookup(waddr[i]);
    end
    add_cmd(ia_pkg::RESET, 0, '0, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::READ, 9, '0, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::SET_INIT_START, 4, '0, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::INIT_INC, 7, 32'd100, 15, 0, 1'b0, ia_pkg::RDY);
    for (int a = 4; a < 8; a++) begin
      add_cmd(ia_pkg::READ, a, '0, 15, 0, 1'b0, ia_pkg::RDY);
    end
    add_cmd(ia_pkg::INIT, 11, 32'h5a5a_0001, 15, 0, 1'b0, ia_pkg::RDY); // Resumes at entry 8
    add_cmd(ia_pkg::READ, 10, '0, 15, 0, 1'b0, ia_pkg::RDY);
    add_lookup(6);
    add_cmd(ia_pkg::COMPARE, 0, 32'd102, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::COMPARE, 0, 32'h5a5a_0001, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::COMPARE, 0, `IA_RESET_DATA, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::COMPARE, 0, 32'hdead_beef, 15, 0, 1'b0, ia_pkg::RDY);
    key = $random(seed);
    add_cmd(ia_pkg::WRITE, 2, key, 15, 40, 1'b0, ia_pkg::RDY); // Released before timeout
    add_cmd(ia_pkg::READ, 2, '0, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::WRITE, 3, ~key, 15, 70, 1'b0, ia_pkg::TMO);
    add_cmd(ia_pkg::ACK_ERROR, 0, '0, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::READ, 3, '0, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::READ, 9, '0, 7, 0, 1'b0, ia_pkg::NXM);
    add_cmd(ia_pkg::ACK_ERROR, 0, '0, 7, 0, 1'b0, ia_pkg::RDY);
    add_cmd(4'hb, 0, '0, 15, 0, 1'b0, ia_pkg::UOP);
    add_cmd(ia_pkg::ACK_ERROR, 0, '0, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::WRITE, 1, key, 15, 5, 1'b1, ia_pkg::OVR);
    add_cmd(ia_pkg::ACK_ERROR, 0, '0, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::READ, 1, '0, 15, 0, 1'b0, ia_pkg::RDY);
    add_cmd(ia_pkg::DISABLE, 0, '0, 15, 0, 1'b0, ia_pkg::PDN);
  endtask

  task automatic run_row(input int r);
    int   cyc;
    logic yield_seen;
    yield_seen = 1'b0;
    if (row_hw[r]) begin
      hw_addr = row_addr[r];
      hw_req  = 1'b1;
      @(negedge clk);
      hw_req = 1'b0;
      check_val($sformatf("row %0d hw_rdat", r), hw_rdat, row_rd[r]);
    end else begin
      cmnd_op    = ia_pkg::ia_op_e'(row_op[r]);
      cmnd_addr  = row_addr[r];
      wr_dat     = row_data[r];
      addr_limit = row_limit[r];
      hw_req     = (row_hold[r] > 0);
      wr_stb     = 1'b1;
      @(negedge clk);
      wr_stb = 1'b0;
      cyc    = 1;
      while (cyc < row_hold[r]) begin
        if (yield) yield_seen = 1'b1;
        if (cyc < STALL_MAX && stat_code != ia_pkg::BSY) begin
          n_errors++;
          $display("Fail at %0d ns: row %0d left BSY while stalled", $time, r);
        end
        @(negedge clk);
        cyc++;
      end
      if (yield) yield_seen = 1'b1;
      if (row_ovr[r]) begin
        cmnd_op   = ia_pkg::READ;
        cmnd_addr = '0;
        wr_stb    = 1'b1;
        @(negedge clk);
        wr_stb = 1'b0;
      end
      hw_req = 1'b0;
      while (stat_code == ia_pkg::BSY) begin
        @(negedge clk);
      end
      check_val($sformatf("row %0d stat_code", r), ia_pkg::ia_data_t'(stat_code),
                ia_pkg::ia_data_t'(row_stat[r]));
      check_val($sformatf("row %0d rd_dat", r), rd_dat, row_rd[r]);
      check_val($sformatf("row %0d enable", r), ia_pkg::ia_data_t'(enable),
                ia_pkg::ia_data_t'(row_ena[r]));
      if (row_hold[r] > 0) begin
        check_val($sformatf("row %0d yield seen", r), ia_pkg::ia_data_t'(yield_seen),
                  ia_pkg::ia_data_t'(row_hold[r] > YIELD_AT));
      end
    end
  endtask

  initial begin : watchdog
    @(posedge clk);
    while (cycle_limit == 0 || cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run hung: no result after %0d cycles", cycle_cnt);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    wr_stb     = 1'b0;
    reg_addr   = `IA_CMND_ADDR;
    cmnd_op    = ia_pkg::NOP;
    cmnd_addr  = '0;
    wr_dat     = '0;
    addr_limit = '1;
    hw_req     = 1'b0;
    hw_addr    = '0;
    seed       = 32'hcc56f061;
    n_errors   = 0;
    n_checks   = 0;
    n_rows     = 0;
    model_ena  = 1'b0;
    model_rd   = '0;
    model_fill = '0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      model_mem[i] = '0;
    end
    build_table();
    cycle_limit = n_rows * 200;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_val("stat_code after reset", ia_pkg::ia_data_t'(stat_code),
              ia_pkg::ia_data_t'(ia_pkg::PDN));
    check_val("enable after reset", ia_pkg::ia_data_t'(enable), '0);
    check_val("rd_dat after reset", rd_dat, '0);
    check_val("yield after reset", ia_pkg::ia_data_t'(yield), '0);
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
